//--- rtl/nts_tx_bank.sv
// One transmit packet bank with sequential word writes, length bookkeeping
// and word-per-cycle readout toward the dispatcher
`timescale 1ns/1ns

module nts_tx_bank #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                           i_clk,
  input  logic                           i_areset,
  input  nts_tx_ctrl_pkg::parser_cmd_t   i_parser_cmd,
  input  nts_tx_ctrl_pkg::dispatch_cmd_t i_dispatch_cmd,
  input  logic                           i_ext_rd_en,
  input  logic [ADDR_WIDTH-1:0]          i_ext_rd_addr,
  output nts_tx_ctrl_pkg::bank_status_t  o_status
);

  localparam logic [ADDR_WIDTH-1:0] ADDR_LAST   = '1;
  localparam logic [ADDR_WIDTH-1:0] ADDR_ALMOST = ADDR_LAST - 1'b1;
  localparam int                    BPW         = nts_tx_types_pkg::BYTES_PER_WORD;

  nts_tx_types_pkg::tx_word_t mem [2**ADDR_WIDTH];

  nts_tx_ctrl_pkg::bank_state_e  state;
  logic [ADDR_WIDTH-1:0]         wr_ptr;
  // One extra bit so the pointer can step past the last index
  logic [ADDR_WIDTH:0]           rd_ptr;
  logic [ADDR_WIDTH-1:0]         last_word;
  nts_tx_types_pkg::last_bytes_t last_bytes;
  nts_tx_types_pkg::tx_word_t    rd_data;
  logic                          rd_valid;

  logic                  fifo_mode;
  logic                  fifo_rd;
  logic                  accept_write;
  logic                  mem_rd;
  logic [ADDR_WIDTH-1:0] mem_rd_addr;
  logic [ADDR_WIDTH-1:0] len_words;
  logic [2:0]            len_rem;
  logic                  full;

  assign fifo_mode    = state inside {nts_tx_ctrl_pkg::BANK_FIFO_OUT,
                                      nts_tx_ctrl_pkg::BANK_FIFO_TRANSMIT};
  assign fifo_rd      = (state == nts_tx_ctrl_pkg::BANK_FIFO_TRANSMIT) &&
                        (rd_ptr <= {1'b0, last_word});
  assign accept_write = i_parser_cmd.write_en && !fifo_mode;

  // The FIFO readout owns the read port once the bank is handed over
  assign mem_rd      = fifo_rd || (i_ext_rd_en && !fifo_mode);
  assign mem_rd_addr = fifo_mode ? rd_ptr[ADDR_WIDTH-1:0] : i_ext_rd_addr;

  assign len_words = ADDR_WIDTH'(i_parser_cmd.length_bytes / BPW);
  assign len_rem   = 3'(i_parser_cmd.length_bytes % BPW);

  assign full = (state == nts_tx_ctrl_pkg::BANK_HAS_DATA) &&
                ((wr_ptr == ADDR_LAST) ||
                 (wr_ptr == ADDR_ALMOST && i_parser_cmd.write_en));

  always_ff @(posedge i_clk) begin
    if (accept_write) begin
      mem[wr_ptr] <= i_parser_cmd.write_data;
    end
    if (mem_rd) begin
      rd_data <= mem[mem_rd_addr];
    end
  end

  // --------------------------------------------------------------------------
  // Bank state machine
  // --------------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state      <= nts_tx_ctrl_pkg::BANK_EMPTY;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      last_word  <= '0;
      last_bytes <= '0;
      rd_valid   <= 1'b0;
    end else begin
      rd_valid <= fifo_rd;
      if (i_parser_cmd.clear) begin
        state  <= nts_tx_ctrl_pkg::BANK_EMPTY;
        wr_ptr <= '0;
        rd_ptr <= '0;
      end else if (!fifo_mode) begin
        if (accept_write) begin
          wr_ptr <= wr_ptr + 1'b1;
          state  <= nts_tx_ctrl_pkg::BANK_HAS_DATA;
        end
        if (state == nts_tx_ctrl_pkg::BANK_HAS_DATA && i_parser_cmd.update_length) begin
          if (i_parser_cmd.length_bytes == '0) begin
            last_word  <= '0;
            last_bytes <= '0;
          end else if (len_rem == '0) begin
            last_word  <= len_words - 1'b1;
            last_bytes <= 4'd8;
          end else begin
            last_word  <= len_words;
            last_bytes <= {1'b0, len_rem};
          end
        end
        if (state == nts_tx_ctrl_pkg::BANK_HAS_DATA && i_parser_cmd.transfer) begin
          state <= nts_tx_ctrl_pkg::BANK_FIFO_OUT;
        end
      end else begin
        if (state == nts_tx_ctrl_pkg::BANK_FIFO_OUT && i_dispatch_cmd.rd_start) begin
          state <= nts_tx_ctrl_pkg::BANK_FIFO_TRANSMIT;
        end
        if (fifo_rd) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
        // Delivered packet returns the bank to the pool
        if (i_dispatch_cmd.packet_read) begin
          state  <= nts_tx_ctrl_pkg::BANK_EMPTY;
          wr_ptr <= '0;
          rd_ptr <= '0;
        end
      end
    end
  end

  assign o_status = '{
    state:      state,
    full:       full,
    rd_data:    rd_data,
    rd_valid:   rd_valid,
    fifo_empty: fifo_mode && (rd_ptr > {1'b0, last_word}),
    last_bytes: last_bytes
  };

  // No parser write reaches the bank while it is handed over
  a_no_write_in_fifo : assert property (
    @(posedge i_clk) disable iff (i_areset)
    fifo_mode |-> !i_parser_cmd.write_en
  );

endmodule

//--- rtl/nts_tx_bank_switch.sv
// Bank role switch: routes parser and dispatch commands to the two banks,
// swaps roles on handover and registers the dispatch side outputs
`timescale 1ns/1ns

module nts_tx_bank_switch #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                           i_clk,
  input  logic                           i_areset,
  input  nts_tx_ctrl_pkg::parser_cmd_t   i_parser_cmd,
  input  nts_tx_ctrl_pkg::dispatch_cmd_t i_dispatch_cmd,
  input  logic                           i_sum_en,
  input  logic                           i_csum_rd_en,
  input  logic [ADDR_WIDTH-1:0]          i_csum_rd_addr,
  input  nts_tx_ctrl_pkg::bank_status_t  i_bank0_status,
  input  nts_tx_ctrl_pkg::bank_status_t  i_bank1_status,
  output nts_tx_ctrl_pkg::parser_cmd_t   o_bank0_parser_cmd,
  output nts_tx_ctrl_pkg::parser_cmd_t   o_bank1_parser_cmd,
  output nts_tx_ctrl_pkg::dispatch_cmd_t o_bank0_dispatch_cmd,
  output nts_tx_ctrl_pkg::dispatch_cmd_t o_bank1_dispatch_cmd,
  output logic                           o_bank0_ext_rd_en,
  output logic                           o_bank1_ext_rd_en,
  output logic [ADDR_WIDTH-1:0]          o_bank_ext_rd_addr,
  output nts_tx_types_pkg::tx_word_t     o_csum_rd_data,
  output logic                           o_packet_available,
  output logic                           o_fifo_empty,
  output logic                           o_fifo_rd_valid,
  output nts_tx_types_pkg::tx_word_t     o_fifo_rd_data,
  output nts_tx_types_pkg::last_bytes_t  o_bytes_last_word,
  output logic                           o_parser_empty,
  output logic                           o_parser_full,
  output logic                           o_error
);

  // Bank currently owned by the parser, the other one dispatches
  logic parser_sel;
  logic swap;

  nts_tx_ctrl_pkg::bank_status_t parser_status;
  nts_tx_ctrl_pkg::bank_status_t dispatch_status;

  assign parser_status   = parser_sel ? i_bank1_status : i_bank0_status;
  assign dispatch_status = parser_sel ? i_bank0_status : i_bank1_status;

  assign swap = (parser_status.state == nts_tx_ctrl_pkg::BANK_FIFO_OUT) &&
                (dispatch_status.state == nts_tx_ctrl_pkg::BANK_EMPTY);

  assign o_bank0_parser_cmd   = parser_sel ? '0 : i_parser_cmd;
  assign o_bank1_parser_cmd   = parser_sel ? i_parser_cmd : '0;
  assign o_bank0_dispatch_cmd = parser_sel ? i_dispatch_cmd : '0;
  assign o_bank1_dispatch_cmd = parser_sel ? '0 : i_dispatch_cmd;

  // Checksum reads go to the parser bank only
  assign o_bank0_ext_rd_en  = i_csum_rd_en && !parser_sel;
  assign o_bank1_ext_rd_en  = i_csum_rd_en && parser_sel;
  assign o_bank_ext_rd_addr = i_csum_rd_addr;
  assign o_csum_rd_data     = parser_status.rd_data;

  assign o_parser_empty = parser_status.state == nts_tx_ctrl_pkg::BANK_EMPTY;
  assign o_parser_full  = parser_status.full;

  always_ff @(posedge i_clk) begin
    o_fifo_rd_data <= dispatch_status.rd_data;
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      parser_sel         <= 1'b0;
      o_packet_available <= 1'b0;
      o_fifo_empty       <= 1'b0;
      o_fifo_rd_valid    <= 1'b0;
      o_bytes_last_word  <= '0;
      o_error            <= 1'b0;
    end else begin
      if (swap) begin
        parser_sel <= !parser_sel;
      end
      o_packet_available <= dispatch_status.state == nts_tx_ctrl_pkg::BANK_FIFO_OUT;
      o_fifo_empty       <= dispatch_status.fifo_empty;
      o_fifo_rd_valid    <= dispatch_status.rd_valid;
      o_bytes_last_word  <= dispatch_status.last_bytes;
      // Commands that need packet data while the parser bank holds none
      o_error <= o_parser_empty &&
                 (i_parser_cmd.update_length || i_parser_cmd.transfer || i_sum_en);
    end
  end

endmodule

//--- rtl/nts_tx_buffer.sv
// Double-buffered transmit packet buffer for the time server
// Two banks alternate between parser fill and dispatcher readout
`timescale 1ns/1ns

module nts_tx_buffer #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                          i_clk,
  input  logic                          i_areset,
  input  logic                          i_write_en,
  input  nts_tx_types_pkg::tx_word_t    i_write_data,
  input  logic                          i_parser_update_length,
  input  logic [15:0]                   i_length_bytes,
  input  logic                          i_parser_transfer,
  input  logic                          i_parser_clear,
  input  logic                          i_sum_reset,
  input  nts_tx_types_pkg::csum_t       i_sum_reset_value,
  input  logic                          i_sum_en,
  input  logic [ADDR_WIDTH-1:0]         i_sum_addr,
  input  logic [ADDR_WIDTH+2:0]         i_sum_bytes,
  input  logic                          i_dispatch_tx_fifo_rd_start,
  input  logic                          i_dispatch_tx_packet_read,
  output logic                          o_dispatch_tx_packet_available,
  output logic                          o_dispatch_tx_fifo_empty,
  output logic                          o_dispatch_tx_fifo_rd_valid,
  output nts_tx_types_pkg::tx_word_t    o_dispatch_tx_fifo_rd_data,
  output nts_tx_types_pkg::last_bytes_t o_dispatch_tx_bytes_last_word,
  output nts_tx_types_pkg::csum_t       o_sum,
  output logic                          o_sum_done,
  output logic                          o_parser_current_empty,
  output logic                          o_parser_current_memory_full,
  output logic                          o_error
);

  nts_tx_ctrl_pkg::parser_cmd_t   parser_cmd;
  nts_tx_ctrl_pkg::dispatch_cmd_t dispatch_cmd;
  nts_tx_ctrl_pkg::parser_cmd_t   bank_parser_cmd [2];
  nts_tx_ctrl_pkg::dispatch_cmd_t bank_dispatch_cmd [2];
  nts_tx_ctrl_pkg::bank_status_t  bank_status [2];
  logic                           bank_ext_rd_en [2];
  logic [ADDR_WIDTH-1:0]          bank_ext_rd_addr;
  logic                           csum_rd_en;
  logic [ADDR_WIDTH-1:0]          csum_rd_addr;
  nts_tx_types_pkg::tx_word_t     csum_rd_data;

  assign parser_cmd = '{
    write_en:      i_write_en,
    write_data:    i_write_data,
    update_length: i_parser_update_length,
    length_bytes:  i_length_bytes,
    transfer:      i_parser_transfer,
    clear:         i_parser_clear
  };

  assign dispatch_cmd = '{
    rd_start:    i_dispatch_tx_fifo_rd_start,
    packet_read: i_dispatch_tx_packet_read
  };

  nts_tx_bank #(.ADDR_WIDTH(ADDR_WIDTH)) u_bank0 (
    .i_clk          (i_clk),
    .i_areset       (i_areset),
    .i_parser_cmd   (bank_parser_cmd[0]),
    .i_dispatch_cmd (bank_dispatch_cmd[0]),
    .i_ext_rd_en    (bank_ext_rd_en[0]),
    .i_ext_rd_addr  (bank_ext_rd_addr),
    .o_status       (bank_status[0])
  );

  nts_tx_bank #(.ADDR_WIDTH(ADDR_WIDTH)) u_bank1 (
    .i_clk          (i_clk),
    .i_areset       (i_areset),
    .i_parser_cmd   (bank_parser_cmd[1]),
    .i_dispatch_cmd (bank_dispatch_cmd[1]),
    .i_ext_rd_en    (bank_ext_rd_en[1]),
    .i_ext_rd_addr  (bank_ext_rd_addr),
    .o_status       (bank_status[1])
  );

  nts_tx_checksum #(.ADDR_WIDTH(ADDR_WIDTH)) u_checksum (
    .i_clk             (i_clk),
    .i_areset          (i_areset),
    .i_sum_reset       (i_sum_reset),
    .i_sum_reset_value (i_sum_reset_value),
    .i_sum_en          (i_sum_en),
    .i_sum_addr        (i_sum_addr),
    .i_sum_bytes       (i_sum_bytes),
    .i_rd_data         (csum_rd_data),
    .o_rd_en           (csum_rd_en),
    .o_rd_addr         (csum_rd_addr),
    .o_sum             (o_sum),
    .o_sum_done        (o_sum_done)
  );

  nts_tx_bank_switch #(.ADDR_WIDTH(ADDR_WIDTH)) u_bank_switch (
    .i_clk                (i_clk),
    .i_areset             (i_areset),
    .i_parser_cmd         (parser_cmd),
    .i_dispatch_cmd       (dispatch_cmd),
    .i_sum_en             (i_sum_en),
    .i_csum_rd_en         (csum_rd_en),
    .i_csum_rd_addr       (csum_rd_addr),
    .i_bank0_status       (bank_status[0]),
    .i_bank1_status       (bank_status[1]),
    .o_bank0_parser_cmd   (bank_parser_cmd[0]),
    .o_bank1_parser_cmd   (bank_parser_cmd[1]),
    .o_bank0_dispatch_cmd (bank_dispatch_cmd[0]),
    .o_bank1_dispatch_cmd (bank_dispatch_cmd[1]),
    .o_bank0_ext_rd_en    (bank_ext_rd_en[0]),
    .o_bank1_ext_rd_en    (bank_ext_rd_en[1]),
    .o_bank_ext_rd_addr   (bank_ext_rd_addr),
    .o_csum_rd_data       (csum_rd_data),
    .o_packet_available   (o_dispatch_tx_packet_available),
    .o_fifo_empty         (o_dispatch_tx_fifo_empty),
    .o_fifo_rd_valid      (o_dispatch_tx_fifo_rd_valid),
    .o_fifo_rd_data       (o_dispatch_tx_fifo_rd_data),
    .o_bytes_last_word    (o_dispatch_tx_bytes_last_word),
    .o_parser_empty       (o_parser_current_empty),
    .o_parser_full        (o_parser_current_memory_full),
    .o_error              (o_error)
  );

endmodule

//--- rtl/nts_tx_checksum.sv
// Internet checksum engine over the parser bank
// Reads one word per cycle and folds masked byte pairs through two adder stages
`timescale 1ns/1ns

module nts_tx_checksum #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                       i_clk,
  input  logic                       i_areset,
  input  logic                       i_sum_reset,
  input  nts_tx_types_pkg::csum_t    i_sum_reset_value,
  input  logic                       i_sum_en,
  input  logic [ADDR_WIDTH-1:0]      i_sum_addr,
  input  logic [ADDR_WIDTH+2:0]      i_sum_bytes,
  input  nts_tx_types_pkg::tx_word_t i_rd_data,
  output logic                       o_rd_en,
  output logic [ADDR_WIDTH-1:0]      o_rd_addr,
  output nts_tx_types_pkg::csum_t    o_sum,
  output logic                       o_sum_done
);

  typedef logic [ADDR_WIDTH+2:0] count_t;

  localparam int     BPW        = nts_tx_types_pkg::BYTES_PER_WORD;
  localparam count_t WORD_BYTES = count_t'(BPW);

  logic                  busy;
  logic [ADDR_WIDTH-1:0] addr;
  count_t                remaining;
  count_t                data_cnt;
  logic                  data_valid;
  logic                  data_last;
  logic                  s0_valid;
  logic                  s0_last;
  logic [15:0]           s0_sum;
  logic [2:0]            s0_carry;
  nts_tx_types_pkg::csum_t acc;
  logic                    done;

  nts_tx_types_pkg::tx_word_t masked;
  logic [15:0] sum_a;
  logic [15:0] sum_b;
  logic [15:0] sum_c;
  logic [2:0]  carry;
  logic [15:0] sum_d;
  logic        carry_d;
  logic [2:0]  msb;
  logic [15:0] sum_e;
  logic        carry_e;

  // --------------------------------------------------------------------------
  // Stage 0 masks bytes past the count and adds the four lanes
  // --------------------------------------------------------------------------

  always_comb begin
    for (int j = 0; j < BPW; j++) begin
      masked[63-8*j -: 8] = (data_cnt > count_t'(j)) ? i_rd_data[63-8*j -: 8] : 8'h00;
    end
  end

  assign {carry[0], sum_a} = {1'b0, masked[63:48]} + {1'b0, masked[47:32]};
  assign {carry[1], sum_b} = {1'b0, masked[31:16]} + {1'b0, masked[15:0]};
  assign {carry[2], sum_c} = {1'b0, sum_a} + {1'b0, sum_b};

  // --------------------------------------------------------------------------
  // Stage 1 adds into the accumulator with end-around carry
  // --------------------------------------------------------------------------

  assign {carry_d, sum_d} = {1'b0, acc} + {1'b0, s0_sum};
  assign msb = {2'b00, s0_carry[0]} + {2'b00, s0_carry[1]} +
               {2'b00, s0_carry[2]} + {2'b00, carry_d};
  assign {carry_e, sum_e} = {1'b0, sum_d} + {14'h0, msb};

  always_ff @(posedge i_clk) begin
    s0_sum   <= sum_c;
    s0_carry <= carry;
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      busy       <= 1'b0;
      addr       <= '0;
      remaining  <= '0;
      data_cnt   <= '0;
      data_valid <= 1'b0;
      data_last  <= 1'b0;
      s0_valid   <= 1'b0;
      s0_last    <= 1'b0;
      acc        <= '0;
      done       <= 1'b0;
    end else begin
      if (i_sum_en && i_sum_bytes != '0) begin
        busy      <= 1'b1;
        addr      <= i_sum_addr;
        remaining <= i_sum_bytes;
      end else if (busy) begin
        addr <= addr + 1'b1;
        if (remaining <= WORD_BYTES) begin
          busy      <= 1'b0;
          remaining <= '0;
        end else begin
          remaining <= remaining - WORD_BYTES;
        end
      end
      // Count follows the word through the memory read cycle
      data_valid <= busy;
      data_cnt   <= remaining;
      data_last  <= busy && (remaining <= WORD_BYTES);
      s0_valid   <= data_valid;
      s0_last    <= data_last;
      if (i_sum_reset) begin
        acc <= i_sum_reset_value;
      end else if (s0_valid) begin
        acc <= sum_e + {15'h0, carry_e};
      end
      done <= (s0_valid && s0_last) || (i_sum_en && i_sum_bytes == '0);
    end
  end

  assign o_rd_en    = busy;
  assign o_rd_addr  = addr;
  assign o_sum      = acc;
  assign o_sum_done = done;

  // No new checksum starts while words are still in the adder pipeline
  a_single_sum : assert property (
    @(posedge i_clk) disable iff (i_areset)
    (busy || data_valid || s0_valid) |-> !i_sum_en
  );

endmodule

//--- rtl/nts_tx_ctrl_pkg.sv
// Control types for the transmit packet buffer
// Bank state machine encoding and the command and status structs

package nts_tx_ctrl_pkg;

  typedef enum logic [2:0] {
    BANK_EMPTY,
    BANK_HAS_DATA,
    BANK_FIFO_OUT,
    BANK_FIFO_TRANSMIT
  } bank_state_e;

  // Parser side command toward one bank
  typedef struct packed {
    logic                       write_en;
    nts_tx_types_pkg::tx_word_t write_data;
    logic                       update_length;
    logic [15:0]                length_bytes;
    logic                       transfer;
    logic                       clear;
  } parser_cmd_t;

  typedef struct packed {
    logic rd_start;
    logic packet_read;
  } dispatch_cmd_t;

  // Bank state and its shared read port result
  typedef struct packed {
    bank_state_e                   state;
    logic                          full;
    nts_tx_types_pkg::tx_word_t    rd_data;
    logic                          rd_valid;
    logic                          fifo_empty;
    nts_tx_types_pkg::last_bytes_t last_bytes;
  } bank_status_t;

endpackage

//--- rtl/nts_tx_types_pkg.sv
// Datapath types for the transmit packet buffer
// Word, checksum and last-word byte count definitions

package nts_tx_types_pkg;

  // --------------------------------------------------------------------------
  // Word and checksum types
  // --------------------------------------------------------------------------

  // One memory or dispatch word
  typedef logic [63:0] tx_word_t;

  // Internet checksum value
  typedef logic [15:0] csum_t;

  // Valid bytes in the last word of a packet, 0 to 8
  typedef logic [3:0] last_bytes_t;

  // --------------------------------------------------------------------------
  // Constants
  // --------------------------------------------------------------------------

  localparam int BYTES_PER_WORD = 8;

endpackage

//--- run_sim.sh
#!/bin/sh
# Compile and run the transmit buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module tb_nts_tx_buffer \
  --Mdir obj_dir -o tb_nts_tx_buffer \
  && ./obj_dir/tb_nts_tx_buffer \
  | awk '{ print } /TESTBENCH PASSED/ { found = 1 } END { exit !found }' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- sim.f
+incdir+include
rtl/nts_tx_types_pkg.sv
rtl/nts_tx_ctrl_pkg.sv
rtl/nts_tx_bank.sv
rtl/nts_tx_checksum.sv
rtl/nts_tx_bank_switch.sv
rtl/nts_tx_buffer.sv
tests/tb_nts_tx_buffer.sv

//--- include/nts_tx_tb_model.svh
// Reference models for the transmit buffer testbench
// Internet checksum over packet words and the length to last-word encoding
`ifndef NTS_TX_TB_MODEL_SVH
`define NTS_TX_TB_MODEL_SVH

// Ones' complement sum, most significant byte of each word first
function automatic logic [15:0] model_csum(input logic [15:0] start,
                                           input logic [63:0] words [$],
                                           input int nbytes);
  logic [31:0] acc;
  logic [7:0]  hi;
  logic [7:0]  lo;
  acc = {16'h0, start};
  for (int i = 0; i < nbytes; i += 2) begin
    hi = words[i / 8][63 - 8 * (i % 8) -: 8];
    lo = (i + 1 < nbytes) ? words[(i + 1) / 8][63 - 8 * ((i + 1) % 8) -: 8] : 8'h00;
    acc = acc + {16'h0, hi, lo};
    acc = {16'h0, acc[15:0]} + {16'h0, acc[31:16]};
  end
  return acc[15:0];
endfunction

// Last word index and its valid byte count for a length in bytes
function automatic void model_length(input int len, output int last_idx,
                                     output int last_bytes);
  if (len == 0) begin
    last_idx   = 0;
    last_bytes = 0;
  end else if (len % 8 == 0) begin
    last_idx   = len / 8 - 1;
    last_bytes = 8;
  end else begin
    last_idx   = len / 8;
    last_bytes = len % 8;
  end
endfunction

`endif

//--- tests/tb_nts_tx_buffer.sv
// Testbench for the double-buffered transmit packet buffer
// Drives packets, checksums and bank swaps and checks the dispatch side
`timescale 1ns/1ns

module tb_nts_tx_buffer;

  localparam int ADDR_WIDTH   = 4;
  localparam int WORDS        = 2**ADDR_WIDTH;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 4;
  localparam int WAIT_LIMIT   = 4 * WORDS;
  localparam int NUM_TESTS    = 5;
  // A test fills at most two banks and waits a bounded time on a few flags
  localparam int TEST_CYCLES  = 2 * WORDS + 4 * WAIT_LIMIT;
  localparam int WATCHDOG_NS  = CLK_PERIOD * (RESET_CYCLES + 2 * NUM_TESTS * TEST_CYCLES);

  `include "nts_tx_tb_model.svh"

  logic                  i_clk;
  logic                  i_areset;
  logic                  i_write_en;
  logic [63:0]           i_write_data;
  logic                  i_parser_update_length;
  logic [15:0]           i_length_bytes;
  logic                  i_parser_transfer;
  logic                  i_parser_clear;
  logic                  i_sum_reset;
  logic [15:0]           i_sum_reset_value;
  logic                  i_sum_en;
  logic [ADDR_WIDTH-1:0] i_sum_addr;
  logic [ADDR_WIDTH+2:0] i_sum_bytes;
  logic                  i_dispatch_tx_fifo_rd_start;
  logic                  i_dispatch_tx_packet_read;
  logic                  o_dispatch_tx_packet_available;
  logic                  o_dispatch_tx_fifo_empty;
  logic                  o_dispatch_tx_fifo_rd_valid;
  logic [63:0]           o_dispatch_tx_fifo_rd_data;
  logic [3:0]            o_dispatch_tx_bytes_last_word;
  logic [15:0]           o_sum;
  logic                  o_sum_done;
  logic                  o_parser_current_empty;
  logic                  o_parser_current_memory_full;
  logic                  o_error;

  int          seed = 15590;
  int          errors = 0;
  int          checks = 0;
  logic [63:0] exp_q [$];
  logic        in_burst = 1'b0;

  nts_tx_buffer #(.ADDR_WIDTH(ADDR_WIDTH)) u_nts_tx_buffer (.*);

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // ----------------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------------

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // Advance one edge and drop every strobe
  task automatic next_cycle();
    @(posedge i_clk);
    i_write_en                  <= 1'b0;
    i_parser_update_length      <= 1'b0;
    i_parser_transfer           <= 1'b0;
    i_parser_clear              <= 1'b0;
    i_sum_reset                 <= 1'b0;
    i_sum_en                    <= 1'b0;
    i_dispatch_tx_fifo_rd_start <= 1'b0;
    i_dispatch_tx_packet_read   <= 1'b0;
  endtask

  task automatic wait_flag(input int which, input string what);
    logic flag;
    for (int i = 0; i < WAIT_LIMIT; i++) begin
      next_cycle();
      #1;
      case (which)
        0:       flag = o_dispatch_tx_packet_available;
        1:       flag = o_dispatch_tx_fifo_empty;
        default: flag = o_parser_current_empty;
      endcase
      if (flag) return;
    end
    errors++;
    $display("Timeout at %0t: %s never came", $time, what);
  endtask

  task automatic write_words(input int n, ref logic [63:0] words [$]);
    logic [63:0] w;
    words.delete();
    for (int i = 0; i < n; i++) begin
      w = {$random(seed), $random(seed)};
      next_cycle();
      i_write_en   <= 1'b1;
      i_write_data <= w;
      words.push_back(w);
    end
  endtask

  task automatic length_and_transfer(input int len);
    next_cycle();
    i_parser_update_length <= 1'b1;
    i_length_bytes         <= 16'(len);
    next_cycle();
    i_parser_transfer <= 1'b1;
    next_cycle();
  endtask

  task automatic stream_packet(ref logic [63:0] words [$], input int len);
    int last_idx;
    int last_bytes;
    model_length(len, last_idx, last_bytes);
    wait_flag(0, "packet available");
    check_eq(64'(o_dispatch_tx_bytes_last_word), 64'(last_bytes), "bytes in last word");
    for (int i = 0; i <= last_idx; i++) begin
      exp_q.push_back(words[i]);
    end
    next_cycle();
    i_dispatch_tx_fifo_rd_start <= 1'b1;
    wait_flag(1, "fifo empty");
    next_cycle();
    #1;
    check_eq(64'(exp_q.size()), 64'd0, "words still expected");
    next_cycle();
    i_dispatch_tx_packet_read <= 1'b1;
    next_cycle();
  endtask

  task automatic run_checksum(ref logic [63:0] words [$], input logic [15:0] start,
                              input int nbytes);
    int          cycles;
    logic [15:0] exp_sum;
    exp_sum = model_csum(start, words, nbytes);
    next_cycle();
    i_sum_reset       <= 1'b1;
    i_sum_reset_value <= start;
    next_cycle();
    i_sum_en    <= 1'b1;
    i_sum_addr  <= '0;
    i_sum_bytes <= (ADDR_WIDTH+3)'(nbytes);
    cycles = 0;
    do begin
      next_cycle();
      cycles++;
      #1;
    end while (!o_sum_done && cycles < WAIT_LIMIT);
    check_eq(64'(cycles), 64'(nbytes == 0 ? 1 : (nbytes + 7) / 8 + 3), "cycles to sum done");
    check_eq(64'(o_sum), 64'(exp_sum), "checksum");
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("test %-12s %s", name, (errors == errors_before) ? "ok" : "had errors");
  endtask

  // ----------------------------------------------------------------------------
  // Dispatch scoreboard and pulse assertions
  // ----------------------------------------------------------------------------

  always @(posedge i_clk) begin
    if (!i_areset) begin
      if (o_dispatch_tx_fifo_rd_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Unexpected dispatch word at %0t", $time);
        end else begin
          check_eq(o_dispatch_tx_fifo_rd_data, exp_q.pop_front(), "dispatch word");
        end
        in_burst = exp_q.size() != 0;
      end else if (in_burst) begin
        errors++;
        $display("MISMATCH at %0t: gap in dispatch valid stream", $time);
        in_burst = 1'b0;
      end
    end
  end

  a_done_pulse : assert property (
    @(posedge i_clk) disable iff (i_areset) o_sum_done |=> !o_sum_done
  ) else begin
    errors++;
    $display("MISMATCH at %0t: sum done longer than one cycle", $time);
  end

  a_error_pulse : assert property (
    @(posedge i_clk) disable iff (i_areset) o_error |=> !o_error
  ) else begin
    errors++;
    $display("MISMATCH at %0t: error flag longer than one cycle", $time);
  end

  // ----------------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------------

  initial begin
    logic [63:0] pkt_a [$];
    logic [63:0] pkt_b [$];
    int          mark;
    int          k;
    int          len_a;
    int          len_b;
    i_clk = 1'b0;
    i_areset = 1'b1;
    i_write_en = 1'b0;
    i_write_data = '0;
    i_parser_update_length = 1'b0;
    i_length_bytes = '0;
    i_parser_transfer = 1'b0;
    i_parser_clear = 1'b0;
    i_sum_reset = 1'b0;
    i_sum_reset_value = '0;
    i_sum_en = 1'b0;
    i_sum_addr = '0;
    i_sum_bytes = '0;
    i_dispatch_tx_fifo_rd_start = 1'b0;
    i_dispatch_tx_packet_read = 1'b0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_areset <= 1'b0;
    #1;

    mark = errors;
    check_eq(64'(o_dispatch_tx_packet_available), 64'd0, "packet available after reset");
    check_eq(64'(o_dispatch_tx_fifo_rd_valid), 64'd0, "rd valid after reset");
    check_eq(64'(o_sum_done), 64'd0, "sum done after reset");
    check_eq(64'(o_error), 64'd0, "error after reset");
    check_eq(64'(o_dispatch_tx_fifo_empty), 64'd0, "fifo empty after reset");
    check_eq(64'(o_parser_current_empty), 64'd1, "parser empty after reset");
    report_test("reset", mark);

    mark = errors;
    k = rand_range(2, 8);
    write_words(k, pkt_a);
    len_a = rand_range(1, 8 * k);
    length_and_transfer(len_a);
    stream_packet(pkt_a, len_a);
    report_test("packet", mark);

    mark = errors;
    k = rand_range(2, 12);
    write_words(k, pkt_b);
    run_checksum(pkt_b, 16'($random(seed)), rand_range(1, 8 * k));
    run_checksum(pkt_b, 16'($random(seed)), 8 * k);
    run_checksum(pkt_b, 16'($random(seed)), 0);
    next_cycle();
    i_parser_clear <= 1'b1;
    wait_flag(2, "parser bank empty after clear");
    report_test("checksum", mark);

    // Second packet fills while the first one waits for the dispatcher
    mark = errors;
    k = rand_range(1, 8);
    write_words(k, pkt_a);
    len_a = rand_range(1, 8 * k);
    length_and_transfer(len_a);
    wait_flag(2, "fresh parser bank");
    k = rand_range(1, 8);
    write_words(k, pkt_b);
    len_b = rand_range(1, 8 * k);
    length_and_transfer(len_b);
    #1;
    check_eq(64'(o_parser_current_empty), 64'd0, "parser bank held while dispatch busy");
    stream_packet(pkt_a, len_a);
    stream_packet(pkt_b, len_b);
    report_test("ping-pong", mark);

    mark = errors;
    next_cycle();
    i_parser_update_length <= 1'b1;
    i_length_bytes         <= 16'd8;
    next_cycle();
    #1;
    check_eq(64'(o_error), 64'd1, "error on update with empty bank");
    write_words(WORDS - 2, pkt_a);
    next_cycle();
    #1;
    check_eq(64'(o_parser_current_memory_full), 64'd0, "full before last words");
    next_cycle();
    i_write_en   <= 1'b1;
    i_write_data <= {$random(seed), $random(seed)};
    #1;
    check_eq(64'(o_parser_current_memory_full), 64'd1, "full with write at last but one");
    next_cycle();
    #1;
    check_eq(64'(o_parser_current_memory_full), 64'd1, "full at last address");
    next_cycle();
    i_parser_clear <= 1'b1;
    wait_flag(2, "parser bank empty after clear");
    report_test("error/full", mark);

    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t, the tests did not finish", $time);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
